// ==== common/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

  localparam int FB_ADDR_W = 16;  // frame buffer address width
  localparam int FB_LEN_W  = 12;  // fill run length width
  localparam int COORD_W   = 12;  // scan counter width, x and y

  // rgb332 pixel as stored in the frame buffer
  typedef struct packed {
    logic [2:0] r;
    logic [2:0] g;
    logic [1:0] b;
  } pixel_t;

  // rgb444 pixel for the dac
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb444_t;

  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,  // no write, credit only
    OP_PIXEL = 2'd1,  // single pixel write
    OP_FILL  = 2'd2   // run of len pixels, same color
  } vga_op_e;

  // host draw command, 38 bits
  typedef struct packed {
    vga_op_e              op;
    logic [FB_ADDR_W-1:0] addr;   // first pixel address
    logic [FB_LEN_W-1:0]  len;    // run length, 0 means 1
    pixel_t               color;
  } draw_cmd_t;

  // frame buffer write port, 25 bits
  typedef struct packed {
    logic                 en;
    logic [FB_ADDR_W-1:0] addr;
    pixel_t               data;
  } fb_wr_t;

  // widen each channel to 4 bits
  function automatic rgb444_t expand_rgb332(input pixel_t p);
    rgb444_t q;
    q.r = {p.r, p.r[2]};  // msb appended
    q.g = {p.g, p.g[2]};
    q.b = {p.b, p.b};     // 2 bits doubled
    return q;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/pixel_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_clk_gen (
  input  wire logic sys_clk_i,      // 100 MHz system clock
  input  wire logic rst_n_i,        // system reset, active low
  output logic      pxl_clk_o,      // pixel clock
  output logic      ready_async_o,  // clock lock, not synchronized
  output logic      pxl_rst_n_o     // pixel domain reset, active low
);

  logic [1:0] rst_sync_r = '0;  // two-flop reset release chain

  logic [1:0] div_cnt_r = '0;  // free running, clock keeps going in reset

  always_ff @(posedge sys_clk_i) begin
    div_cnt_r <= div_cnt_r + 2'd1;  // msb toggles every 2 cycles
  end

  assign pxl_clk_o     = div_cnt_r[1];  // sys clock / 4
  assign ready_async_o = 1'b1;          // divider is always ready

  // hold pixel domain until reset gone and clock ready
  always_ff @(posedge pxl_clk_o) begin
    if (!(rst_n_i && ready_async_o)) begin
      rst_sync_r <= '0;
    end else begin
      rst_sync_r <= {rst_sync_r[0], 1'b1};  // release on 2nd edge
    end
  end

  assign pxl_rst_n_o = rst_sync_r[1];

endmodule

`default_nettype wire

// ==== cmd_queue/cmd_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_queue #(
  parameter int QUEUE_DEPTH = 8  // credits handed to the host
) (
  input  wire logic               sys_clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               cmd_valid_i,  // one per held credit
  input  wire vga_pkg::draw_cmd_t cmd_i,
  output logic                    credit_o,     // one pulse per finished command
  output vga_pkg::fb_wr_t         fb_wr_o
);
  import vga_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  typedef enum logic [1:0] {
    IDLE,   // waiting on fifo, pops here
    PIXEL,  // single write
    FILL,   // run write, one pixel per cycle
    DONE    // credit pulse
  } exec_state_e;

  draw_cmd_t            fifo_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]     wr_ptr_r;
  logic [PTR_W-1:0]     rd_ptr_r;
  logic [CNT_W-1:0]     count_r;     // entries held
  logic                 fifo_pop;
  draw_cmd_t            head_cmd;    // oldest entry
  exec_state_e          state_r;
  logic [FB_ADDR_W-1:0] run_addr_r;  // current write address
  logic [FB_LEN_W-1:0]  run_left_r;  // pixels still to write
  pixel_t               color_r;

  assign head_cmd = fifo_mem[rd_ptr_r];
  assign fifo_pop = (state_r == IDLE) && (count_r != '0);  // one pop per command

  always_ff @(posedge sys_clk_i) begin
    if (cmd_valid_i) begin
      fifo_mem[wr_ptr_r] <= cmd_i;  // credits keep this from overrunning
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (cmd_valid_i) begin
        wr_ptr_r <= (wr_ptr_r == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_r <= (rd_ptr_r == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({cmd_valid_i, fifo_pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;  // both or neither
      endcase
    end
  end

  // executor FSM
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      state_r <= IDLE;
    end else begin
      case (state_r)
        IDLE: begin
          if (fifo_pop) begin
            case (head_cmd.op)
              OP_PIXEL: state_r <= PIXEL;
              OP_FILL:  state_r <= FILL;
              default:  state_r <= DONE;  // nop, and the spare code
            endcase
          end
        end
        PIXEL:   state_r <= DONE;
        FILL:    if (run_left_r == FB_LEN_W'(1)) state_r <= DONE;  // last pixel
        default: state_r <= IDLE;                                  // DONE
      endcase
    end
  end

  // command payload, loaded on pop
  always_ff @(posedge sys_clk_i) begin
    if (fifo_pop) begin
      run_addr_r <= head_cmd.addr;
      run_left_r <= (head_cmd.len == '0) ? FB_LEN_W'(1) : head_cmd.len;  // len 0 acts as 1
      color_r    <= head_cmd.color;
    end else if (state_r == FILL) begin
      run_addr_r <= run_addr_r + 1'b1;  // walk the run
      run_left_r <= run_left_r - 1'b1;
    end
  end

  always_comb begin
    fb_wr_o.en   = (state_r == PIXEL) || (state_r == FILL);
    fb_wr_o.addr = run_addr_r;
    fb_wr_o.data = color_r;
  end

  assign credit_o = (state_r == DONE);  // cycle after last write

endmodule

`default_nettype wire

// ==== frame_buffer/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
  parameter int DEPTH = 128  // pixels, H_ACTIVE * V_ACTIVE
) (
  input  wire logic                            sys_clk_i,  // write clock
  input  wire vga_pkg::fb_wr_t                 wr_i,
  input  wire logic                            pxl_clk_i,  // read clock
  input  wire logic [vga_pkg::FB_ADDR_W-1:0]   rd_addr_i,
  output vga_pkg::pixel_t                      rd_data_o   // 1 cycle after rd_addr_i
);
  import vga_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  pixel_t mem [DEPTH];  // simple dual port, maps to block ram
  pixel_t rd_data_r;

  // start from a black frame
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (wr_i.en && (wr_i.addr < FB_ADDR_W'(DEPTH))) begin  // drop writes past the frame
      mem[wr_i.addr[AW-1:0]] <= wr_i.data;
    end
  end

  always_ff @(posedge pxl_clk_i) begin
    rd_data_r <= mem[rd_addr_i[AW-1:0]];  // registered read
  end

  assign rd_data_o = rd_data_r;

endmodule

`default_nettype wire

// ==== scan_out/scan_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  wire logic                        pxl_clk_i,
  input  wire logic                        pxl_rst_n_i,
  output logic [vga_pkg::COORD_W-1:0]      x_o,      // pixel in line
  output logic [vga_pkg::COORD_W-1:0]      y_o,      // line in frame
  output logic                             hsync_o,  // active low
  output logic                             vsync_o,  // active low
  output logic                             active_o
);
  import vga_pkg::*;

  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HS_START = H_ACTIVE + H_FRONT;  // first sync pixel
  localparam int HS_END   = HS_START + H_SYNC;   // first pixel after sync
  localparam int VS_START = V_ACTIVE + V_FRONT;
  localparam int VS_END   = VS_START + V_SYNC;

  logic [COORD_W-1:0] h_cnt_r;
  logic [COORD_W-1:0] v_cnt_r;
  logic               line_end;

  assign line_end = (h_cnt_r == COORD_W'(H_TOTAL - 1));

  always_ff @(posedge pxl_clk_i) begin
    if (!pxl_rst_n_i) begin
      h_cnt_r <= '0;
      v_cnt_r <= '0;
    end else if (line_end) begin
      h_cnt_r <= '0;
      // line counter only moves at line end, so vsync edges land on line start
      if (v_cnt_r == COORD_W'(V_TOTAL - 1)) begin
        v_cnt_r <= '0;
      end else begin
        v_cnt_r <= v_cnt_r + 1'b1;
      end
    end else begin
      h_cnt_r <= h_cnt_r + 1'b1;
    end
  end

  assign x_o = h_cnt_r;
  assign y_o = v_cnt_r;

  assign hsync_o  = !((h_cnt_r >= COORD_W'(HS_START)) && (h_cnt_r < COORD_W'(HS_END)));
  assign vsync_o  = !((v_cnt_r >= COORD_W'(VS_START)) && (v_cnt_r < COORD_W'(VS_END)));
  assign active_o = (h_cnt_r < COORD_W'(H_ACTIVE)) && (v_cnt_r < COORD_W'(V_ACTIVE));

endmodule

`default_nettype wire

// ==== scan_out/pixel_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_out #(
  parameter int H_ACTIVE = 640,
  parameter int DEPTH    = 640 * 480
) (
  input  wire logic                          pxl_clk_i,
  input  wire logic                          pxl_rst_n_i,
  input  wire logic [vga_pkg::COORD_W-1:0]   x_i,
  input  wire logic [vga_pkg::COORD_W-1:0]   y_i,
  input  wire logic                          hsync_i,
  input  wire logic                          vsync_i,
  input  wire logic                          active_i,
  output logic [vga_pkg::FB_ADDR_W-1:0]      rd_addr_o,
  input  wire vga_pkg::pixel_t               rd_data_i,   // 1 cycle after rd_addr_o
  output logic                               vga_hsync_o,
  output logic                               vga_vsync_o,
  output vga_pkg::rgb444_t                   vga_rgb_o
);
  import vga_pkg::*;

  logic [FB_ADDR_W-1:0] pix_addr;     // y * H_ACTIVE + x
  logic                 hsync_d1_r;   // stage 1, matches ram latency
  logic                 vsync_d1_r;
  logic                 active_d1_r;
  logic                 hsync_d2_r;   // stage 2, output
  logic                 vsync_d2_r;
  rgb444_t              rgb_r;

  assign pix_addr = FB_ADDR_W'(y_i) * FB_ADDR_W'(H_ACTIVE) + FB_ADDR_W'(x_i);

  // blanking reads park on address 0
  assign rd_addr_o = (active_i && (pix_addr < FB_ADDR_W'(DEPTH))) ? pix_addr : '0;

  always_ff @(posedge pxl_clk_i) begin
    if (!pxl_rst_n_i) begin
      hsync_d1_r  <= 1'b1;  // syncs idle high
      vsync_d1_r  <= 1'b1;
      active_d1_r <= 1'b0;
      hsync_d2_r  <= 1'b1;
      vsync_d2_r  <= 1'b1;
      rgb_r       <= '0;    // black out of reset
    end else begin
      hsync_d1_r  <= hsync_i;
      vsync_d1_r  <= vsync_i;
      active_d1_r <= active_i;
      hsync_d2_r  <= hsync_d1_r;
      vsync_d2_r  <= vsync_d1_r;
      rgb_r       <= active_d1_r ? expand_rgb332(rd_data_i) : '0;  // black in blanking
    end
  end

  assign vga_hsync_o = hsync_d2_r;
  assign vga_vsync_o = vsync_d2_r;
  assign vga_rgb_o   = rgb_r;

endmodule

`default_nettype wire

// ==== hdl/vga_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_top #(
  parameter int H_ACTIVE    = 640,
  parameter int H_FRONT     = 16,
  parameter int H_SYNC      = 96,
  parameter int H_BACK      = 48,
  parameter int V_ACTIVE    = 480,
  parameter int V_FRONT     = 10,
  parameter int V_SYNC      = 2,
  parameter int V_BACK      = 33,
  parameter int QUEUE_DEPTH = 8
) (
  input  wire logic               sys_clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               cmd_valid_i,
  input  wire vga_pkg::draw_cmd_t cmd_i,
  output logic                    credit_o,
  output logic                    vga_clk_o,     // pixel clock to the dac
  output logic                    vga_locked_o,
  output logic                    vga_hsync_o,
  output logic                    vga_vsync_o,
  output vga_pkg::rgb444_t        vga_rgb_o
);
  import vga_pkg::*;

  localparam int DEPTH = H_ACTIVE * V_ACTIVE;  // one byte per visible pixel

  logic                 pxl_clk;
  logic                 pxl_rst_n;
  logic                 clk_ready;
  fb_wr_t               fb_wr;
  logic [FB_ADDR_W-1:0] rd_addr;
  pixel_t               rd_data;
  logic [COORD_W-1:0]   scan_x;
  logic [COORD_W-1:0]   scan_y;
  logic                 scan_hsync;
  logic                 scan_vsync;
  logic                 scan_active;

  pixel_clk_gen i_pixel_clk_gen (
    .sys_clk_i    (sys_clk_i),
    .rst_n_i      (rst_n_i),
    .pxl_clk_o    (pxl_clk),
    .ready_async_o(clk_ready),
    .pxl_rst_n_o  (pxl_rst_n)
  );

  cmd_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_cmd_queue (
    .sys_clk_i  (sys_clk_i),
    .rst_n_i    (rst_n_i),
    .cmd_valid_i(cmd_valid_i),
    .cmd_i      (cmd_i),
    .credit_o   (credit_o),
    .fb_wr_o    (fb_wr)
  );

  frame_buffer #(.DEPTH(DEPTH)) i_frame_buffer (
    .sys_clk_i(sys_clk_i),
    .wr_i     (fb_wr),
    .pxl_clk_i(pxl_clk),
    .rd_addr_i(rd_addr),
    .rd_data_o(rd_data)
  );

  scan_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) i_scan_timing (
    .pxl_clk_i  (pxl_clk),
    .pxl_rst_n_i(pxl_rst_n),
    .x_o        (scan_x),
    .y_o        (scan_y),
    .hsync_o    (scan_hsync),
    .vsync_o    (scan_vsync),
    .active_o   (scan_active)
  );

  pixel_out #(.H_ACTIVE(H_ACTIVE), .DEPTH(DEPTH)) i_pixel_out (
    .pxl_clk_i  (pxl_clk),
    .pxl_rst_n_i(pxl_rst_n),
    .x_i        (scan_x),
    .y_i        (scan_y),
    .hsync_i    (scan_hsync),
    .vsync_i    (scan_vsync),
    .active_i   (scan_active),
    .rd_addr_o  (rd_addr),
    .rd_data_i  (rd_data),
    .vga_hsync_o(vga_hsync_o),
    .vga_vsync_o(vga_vsync_o),
    .vga_rgb_o  (vga_rgb_o)
  );

  assign vga_clk_o    = pxl_clk;
  assign vga_locked_o = clk_ready;  // raw lock, for status only

endmodule

`default_nettype wire

// ==== sim/tb_vga_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vga_top;
  import vga_pkg::*;

  localparam int H_ACTIVE    = 16;
  localparam int H_FRONT     = 2;
  localparam int H_SYNC      = 3;
  localparam int H_BACK      = 3;
  localparam int V_ACTIVE    = 8;
  localparam int V_FRONT     = 1;
  localparam int V_SYNC      = 2;
  localparam int V_BACK      = 1;
  localparam int QUEUE_DEPTH = 4;
  localparam int H_TOTAL     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 24 pixels per line
  localparam int V_TOTAL     = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 12 lines per frame
  localparam int FRAME_PIX   = H_ACTIVE * V_ACTIVE;
  localparam int NUM_ROWS    = 15;
  localparam int WAIT_CYCLES = 4000;  // sys cycles against a 1152 cycle frame

  typedef struct packed {
    logic [1:0]  grp;   // test the row belongs to
    vga_op_e     op;
    logic [15:0] addr;
    logic [11:0] len;
    logic [11:0] run;   // pixels the command must write
  } tbl_row_t;

  logic     sys_clk;
  logic     rst_n;
  logic     cmd_valid;
  draw_cmd_t cmd;
  logic     credit;
  logic     vga_clk;
  logic     vga_locked;
  logic     vga_hsync;
  logic     vga_vsync;
  rgb444_t  vga_rgb;

  tbl_row_t    cmd_tbl [NUM_ROWS];
  logic [7:0]  shadow [FRAME_PIX];  // expected frame contents
  logic [31:0] lfsr_q = 32'hc2dc_a492;
  int err_cnt = 0;
  int test_cnt = 0;
  int fail_cnt = 0;
  logic timeout_hit = 1'b0;
  int host_credits = QUEUE_DEPTH;  // host side credit counter
  int sent_cnt = 0;
  int credit_cnt = 0;
  int stall_cnt = 0;               // sends that had to wait for a credit

  // scan-out monitor state
  logic prev_hs;
  logic prev_vs;
  logic h_lock;
  logic v_lock;
  logic hs_seen;
  logic pix_check_en = 1'b0;
  int h_pos;
  int v_pos;
  int hs_low;
  int hs_gap;
  int vs_low;
  int hs_meas = 0;
  int vs_meas = 0;
  int vs_fall_cnt = 0;
  int pix_checked = 0;
  int blank_checked = 0;
  int blank_err = 0;
  time clk_fall_t = 0;             // last pixel clock fall

  vga_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_vga_top (
    .sys_clk_i   (sys_clk),
    .rst_n_i     (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .credit_o    (credit),
    .vga_clk_o   (vga_clk),
    .vga_locked_o(vga_locked),
    .vga_hsync_o (vga_hsync),
    .vga_vsync_o (vga_vsync),
    .vga_rgb_o   (vga_rgb)
  );

  initial sys_clk = 1'b0;
  always #2 sys_clk = ~sys_clk;  // 4 ns period

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // 32 bit fibonacci with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_random(input int nbits, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // rgb332 to rgb444 with msb appended and blue doubled
  function automatic logic [11:0] to_rgb444(input logic [7:0] p);
    return {p[7:5], p[7], p[4:2], p[4], p[1:0], p[1:0]};
  endfunction

  task automatic set_row(input int idx, input logic [1:0] grp, input vga_op_e op,
                         input int addr, input int len, input int run);
    cmd_tbl[idx] = {grp, op, 16'(addr), 12'(len), 12'(run)};
  endtask

  task automatic load_table();
    set_row(0,  2'd0, OP_PIXEL, 0,   0,  1);
    set_row(1,  2'd0, OP_PIXEL, 17,  1,  1);
    set_row(2,  2'd0, OP_PIXEL, 63,  1,  1);
    set_row(3,  2'd0, OP_PIXEL, 127, 1,  1);
    set_row(4,  2'd0, OP_NOP,   5,   3,  0);   // credit only
    set_row(5,  2'd0, OP_PIXEL, 80,  1,  1);
    set_row(6,  2'd1, OP_FILL,  32,  5,  5);
    set_row(7,  2'd1, OP_FILL,  40,  0,  1);   // len 0 writes one pixel
    set_row(8,  2'd1, OP_FILL,  100, 12, 12);
    set_row(9,  2'd1, OP_NOP,   0,   0,  0);
    set_row(10, 2'd2, OP_FILL,  48,  16, 16);  // burst with long fills first
    set_row(11, 2'd2, OP_FILL,  64,  20, 20);
    set_row(12, 2'd2, OP_PIXEL, 2,   1,  1);
    set_row(13, 2'd2, OP_NOP,   9,   0,  0);
    set_row(14, 2'd2, OP_FILL,  120, 8,  8);   // beyond the credits so it must stall
  endtask

  task automatic send_cmd(input tbl_row_t row);
    int waited;
    logic [31:0] rnd;
    waited = 0;
    while (host_credits == 0 && waited < WAIT_CYCLES) begin
      @(posedge sys_clk);
      #1;
      waited++;
    end
    if (host_credits == 0) begin
      $display("timeout: no credit came back within %0d cycles", WAIT_CYCLES);
      timeout_hit = 1'b1;
      return;
    end
    if (waited > 0) stall_cnt++;
    take_random(8, rnd);                 // color for this command
    cmd.op    = row.op;
    cmd.addr  = row.addr;
    cmd.len   = row.len;
    cmd.color = rnd[7:0];
    cmd_valid = 1'b1;
    host_credits--;
    sent_cnt++;
    for (int k = 0; k < int'(row.run); k++) begin
      shadow[int'(row.addr) + k] = rnd[7:0];  // model of the run
    end
    @(posedge sys_clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (host_credits != QUEUE_DEPTH && n < WAIT_CYCLES) begin
      @(posedge sys_clk);
      #1;
      n++;
    end
    if (host_credits != QUEUE_DEPTH) begin
      $display("timeout: queue did not return all credits");
      timeout_hit = 1'b1;
    end
  endtask

  task automatic wait_vsync_fall();
    int n;
    int start;
    n     = 0;
    start = vs_fall_cnt;
    while (vs_fall_cnt == start && n < WAIT_CYCLES) begin
      @(posedge sys_clk);
      #1;
      n++;
    end
    if (vs_fall_cnt == start) begin
      $display("timeout: no vsync pulse seen on the output");
      timeout_hit = 1'b1;
    end
  endtask

  task automatic wait_sync_meas();
    int n;
    n = 0;
    while ((hs_meas < 4 || vs_meas < 1) && n < WAIT_CYCLES) begin
      @(posedge sys_clk);
      #1;
      n++;
    end
    if (hs_meas < 4 || vs_meas < 1) begin
      $display("timeout: sync pulses were not measured");
      timeout_hit = 1'b1;
    end
  endtask

  // compare one whole scanned frame with the shadow
  task automatic scan_and_compare();
    wait_vsync_fall();
    if (timeout_hit) return;
    pix_checked  = 0;
    pix_check_en = 1'b1;
    wait_vsync_fall();
    pix_check_en = 1'b0;
    if (timeout_hit) return;
    check_value("active pixels scanned", 32'(pix_checked), 32'(FRAME_PIX));
  endtask

  task automatic finish_test(input string name, input int err_mark);
    test_cnt++;
    if (timeout_hit || err_cnt != err_mark) begin
      fail_cnt++;
      $display("test %s: FAIL", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic run_group(input logic [1:0] grp, input string name);
    int err_mark;
    int in_grp;
    int stall_mark;
    err_mark   = err_cnt;
    in_grp     = 0;
    stall_mark = stall_cnt;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (cmd_tbl[i].grp == grp && !timeout_hit) begin
        send_cmd(cmd_tbl[i]);
        in_grp++;
        if (grp == 2'd2 && in_grp == QUEUE_DEPTH) begin  // long fill still running
          check_value("host credits after burst", 32'(host_credits), 32'd0);
        end
      end
    end
    if (!timeout_hit) wait_drain();
    if (!timeout_hit && grp == 2'd2) begin
      check_value("stall past the credits", 32'(stall_cnt > stall_mark), 32'd1);
      repeat (32) @(posedge sys_clk);  // no stray credit afterwards
      #1;
      check_value("credit_o pulses", 32'(credit_cnt), 32'(NUM_ROWS));
    end
    if (!timeout_hit) scan_and_compare();
    finish_test(name, err_mark);
  endtask

  // host credit return sampled mid cycle
  always @(negedge sys_clk) begin
    if (rst_n && credit) begin
      check_value("credit_o with nothing outstanding", 32'(sent_cnt > credit_cnt), 32'd1);
      credit_cnt++;
      host_credits++;
      check_value("host credits in range", 32'(host_credits <= QUEUE_DEPTH), 32'd1);
    end
  end

  // scan-out monitor rebuilding position from the output syncs
  always @(negedge vga_clk) begin
    if (!rst_n) begin
      prev_hs = 1'b1;
      prev_vs = 1'b1;
      h_lock  = 1'b0;
      v_lock  = 1'b0;
      hs_seen = 1'b0;
      h_pos   = 0;
      v_pos   = 0;
      hs_low  = 0;
      hs_gap  = 0;
      vs_low  = 0;
    end else begin
      if (clk_fall_t != 0) begin  // four sys clock periods
        check_value("vga_clk_o period", 32'($time - clk_fall_t), 32'd16);
      end
      clk_fall_t = $time;
      h_pos = (h_pos == H_TOTAL - 1) ? 0 : h_pos + 1;
      if (h_pos == 0) v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
      if (prev_hs && !vga_hsync) begin
        if (hs_seen) begin
          check_value("hsync fall spacing", 32'(hs_gap), 32'(H_TOTAL));
          hs_meas++;
        end
        hs_seen = 1'b1;
        hs_gap  = 0;
        h_pos   = H_ACTIVE + H_FRONT;  // first sync pixel
        h_lock  = 1'b1;
      end
      if (!prev_hs && vga_hsync) begin
        check_value("hsync low width", 32'(hs_low), 32'(H_SYNC));
        hs_low = 0;
      end
      if (prev_vs && !vga_vsync) begin
        if (h_lock) check_value("vsync fall line position", 32'(h_pos), 32'd0);
        v_pos  = V_ACTIVE + V_FRONT;  // first sync line
        v_lock = 1'b1;
        vs_fall_cnt++;
      end
      if (!prev_vs && vga_vsync) begin
        check_value("vsync low width", 32'(vs_low), 32'(V_SYNC * H_TOTAL));
        vs_low = 0;
        vs_meas++;
      end
      hs_gap++;
      if (!vga_hsync) hs_low++;
      if (!vga_vsync) vs_low++;
      if (h_lock && v_lock) begin
        if (h_pos < H_ACTIVE && v_pos < V_ACTIVE) begin
          if (pix_check_en) begin
            check_value("vga_rgb_o active pixel", 32'(vga_rgb),
                        32'(to_rgb444(shadow[v_pos * H_ACTIVE + h_pos])));
            pix_checked++;
          end
        end else begin
          if (vga_rgb !== '0) blank_err++;
          check_value("vga_rgb_o in blanking", 32'(vga_rgb), 32'd0);
          blank_checked++;
        end
      end
      prev_hs = vga_hsync;
      prev_vs = vga_vsync;
    end
  end

  initial begin
    int err_mark;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    for (int i = 0; i < FRAME_PIX; i++) begin
      shadow[i] = 8'h00;  // buffer starts black
    end
    load_table();
    repeat (4) @(posedge sys_clk);
    #1;
    rst_n = 1'b1;

    err_mark = err_cnt;
    repeat (16) begin  // pixel domain still held or just released
      check_value("vga_hsync_o after reset", 32'(vga_hsync), 32'd1);
      check_value("vga_vsync_o after reset", 32'(vga_vsync), 32'd1);
      check_value("credit_o after reset", 32'(credit), 32'd0);
      check_value("vga_rgb_o after reset", 32'(vga_rgb), 32'd0);
      check_value("vga_locked_o", 32'(vga_locked), 32'd1);
      @(posedge sys_clk);
      #1;
    end
    finish_test("reset state", err_mark);

    err_mark = err_cnt;
    wait_sync_meas();
    finish_test("sync timing", err_mark);

    if (!timeout_hit) run_group(2'd0, "pixel writes");
    if (!timeout_hit) run_group(2'd1, "run fills");
    if (!timeout_hit) run_group(2'd2, "credit burst");

    err_mark = err_cnt;
    check_value("blanking samples seen", 32'(blank_checked > 0), 32'd1);
    check_value("blanking mismatches", 32'(blank_err), 32'd0);
    finish_test("blanking", err_mark);

    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
    if (timeout_hit || err_cnt != 0 || fail_cnt != 0) begin
      $display("Regression failed");
    end else begin
      $display("Regression passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
common/vga_pkg.sv
hdl/pixel_clk_gen.sv
cmd_queue/cmd_queue.sv
frame_buffer/frame_buffer.sv
scan_out/scan_timing.sv
scan_out/pixel_out.sv
hdl/vga_top.sv
sim/tb_vga_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the VGA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_vga_top \
  -Mdir obj_dir -o tb_vga_top

./obj_dir/tb_vga_top | tee sim.log

if grep -q "Regression failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0
